//--- Bender.yml
package:
  name: rv_pipe_regs

export_include_dirs:
  - .

sources:
  - rv_pipe_pkg.sv
  - fetch_decode_reg.sv
  - decode_exec_reg.sv
  - mem_access_calc.sv
  - exec_mem_reg.sv
  - mem_wb_reg.sv
  - rv_pipe_regs_top.sv
  - target: test
    files:
      - tb_rv_pipe_regs.sv

//--- compile.f
+incdir+.
rv_pipe_pkg.sv
fetch_decode_reg.sv
decode_exec_reg.sv
mem_access_calc.sv
exec_mem_reg.sv
mem_wb_reg.sv
rv_pipe_regs_top.sv
tb_rv_pipe_regs.sv

//--- decode_exec_reg.sv
module decode_exec_reg (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    load_i,
    input  logic                    ready_i,
    input  logic                    valid_i,
    input  rv_pipe_pkg::ctrl_word_t ctrl_i,
    input  rv_pipe_pkg::rv_word_t   u_imm_i,
    output rv_pipe_pkg::ctrl_word_t ctrl_o,
    output rv_pipe_pkg::rv_word_t   u_imm_o,
    output logic                    valid_o,
    output logic                    ready_o
);
    import rv_pipe_pkg::*;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            ctrl_o  <= ctrl_nop;
            valid_o <= 1'b0;
            ready_o <= 1'b0;
        end else if (load_i) begin
            ctrl_o  <= ctrl_i;
            valid_o <= valid_o | valid_i; // stays set once seen
            ready_o <= ready_i;
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            u_imm_o <= u_imm_i;
        end
    end

endmodule

//--- exec_mem_reg.sv
`include "rv_pipe_config.svh"

module exec_mem_reg (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    load_i,
    input  logic                    ready_i,
    input  logic                    br_en_i,
    input  rv_pipe_pkg::ctrl_word_t ctrl_i,
    input  rv_pipe_pkg::rv_word_t   exe_fwd_i,
    input  rv_pipe_pkg::rv_word_t   u_imm_i,
    input  rv_pipe_pkg::mem_req_t   mem_req_i,
    output rv_pipe_pkg::ctrl_word_t ctrl_o,
    output rv_pipe_pkg::rv_word_t   exe_fwd_o,
    output rv_pipe_pkg::rv_word_t   u_imm_o,
    output logic                    br_en_o,
    output logic                    valid_o,
    output logic                    ready_o,
    output rv_pipe_pkg::mem_req_t   mem_req_o
);
    import rv_pipe_pkg::*;

    rv_word_t              addr_q;
    rv_word_t              wdata_q;
    logic [`RV_MASK_W-1:0] byte_en_q;
    logic                  req_load;

    // request only moves when a load or store is latched
    assign req_load = load_i & (ctrl_i.mem.mem_read | ctrl_i.mem.mem_write);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            ctrl_o    <= ctrl_nop;
            exe_fwd_o <= '0;
            br_en_o   <= 1'b0;
            valid_o   <= 1'b0;
            ready_o   <= 1'b0;
        end else if (load_i) begin
            ctrl_o    <= ctrl_i;
            exe_fwd_o <= exe_fwd_i;
            br_en_o   <= br_en_i;
            valid_o   <= 1'b1;
            ready_o   <= ready_i;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            byte_en_q <= '0;
        end else if (req_load) begin
            byte_en_q <= mem_req_i.byte_en;
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            u_imm_o <= u_imm_i;
        end
        if (req_load) begin
            addr_q  <= mem_req_i.addr;
            wdata_q <= mem_req_i.wdata;
        end
    end

    always_comb begin
        mem_req_o.addr    = addr_q;
        mem_req_o.wdata   = wdata_q;
        mem_req_o.byte_en = byte_en_q;
    end

endmodule

//--- fetch_decode_reg.sv
`include "rv_pipe_config.svh"

module fetch_decode_reg (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    load_i,
    input  logic                    ready_i,
    input  rv_pipe_pkg::rv_word_t   instr_i,
    input  rv_pipe_pkg::rv_word_t   pc_i,
    input  rv_pipe_pkg::rv_word_t   pc_next_i,
    output rv_pipe_pkg::rv_word_t   instr_o,
    output rv_pipe_pkg::rv_word_t   pc_o,
    output rv_pipe_pkg::rv_word_t   pc_next_o,
    output logic                    valid_o,
    output logic                    ready_o,
    output logic [`RV_ORDER_W-1:0]  commit_order_o
);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            valid_o        <= 1'b0;
            ready_o        <= 1'b0;
            commit_order_o <= '0;
        end else if (load_i) begin
            valid_o        <= 1'b1; // sticky after first load
            ready_o        <= ready_i;
            commit_order_o <= commit_order_o + `RV_ORDER_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            instr_o   <= instr_i;
            pc_o      <= pc_i;
            pc_next_o <= pc_next_i;
        end
    end

endmodule

//--- mem_access_calc.sv
`include "rv_pipe_config.svh"

module mem_access_calc (
    input  rv_pipe_pkg::ctrl_word_t ctrl_i,
    input  rv_pipe_pkg::rv_word_t   alu_out_i,
    input  rv_pipe_pkg::rv_word_t   u_imm_i,
    input  rv_pipe_pkg::rv_word_t   rs2_data_i,
    input  logic                    br_en_i,
    output rv_pipe_pkg::mem_req_t   mem_req_o,
    output rv_pipe_pkg::rv_word_t   exe_fwd_o
);
    import rv_pipe_pkg::*;

    rv_word_t addr_src;
    logic     is_word;
    logic     is_half;
    logic     is_byte;

    always_comb begin
        case (ctrl_i.mem.mar_sel)
            mar_alu_out: addr_src = alu_out_i;
            default:     addr_src = ctrl_i.pc;
        endcase
    end

    // access size from funct3 decoded per direction
    always_comb begin
        is_word = 1'b0;
        is_half = 1'b0;
        is_byte = 1'b0;
        if (ctrl_i.mem.mem_read) begin
            case (ctrl_i.mem.funct3.ld)
                lw:       is_word = 1'b1;
                lh, lhu:  is_half = 1'b1;
                lb, lbu:  is_byte = 1'b1;
                default:  ; // no lanes
            endcase
        end else if (ctrl_i.mem.mem_write) begin
            case (ctrl_i.mem.funct3.st)
                sw:       is_word = 1'b1;
                sh:       is_half = 1'b1;
                sb:       is_byte = 1'b1;
                default:  ;
            endcase
        end
    end

    always_comb begin
        mem_req_o.addr    = addr_src;
        mem_req_o.wdata   = rs2_data_i;
        mem_req_o.byte_en = '0;
        if (is_word) begin
            mem_req_o.byte_en = '1;
        end else if (is_half || is_byte) begin
            // sub-word access goes out word aligned
            mem_req_o.addr = {addr_src[`RV_XLEN-1:2], 2'b00};
            if (is_half) begin
                mem_req_o.byte_en = `RV_MASK_W'(3) << addr_src[1:0]; // top lane drops off
            end else begin
                mem_req_o.byte_en = `RV_MASK_W'(1) << addr_src[1:0];
            end
        end
    end

    always_comb begin
        case (ctrl_i.exe.exe_fwd_sel)
            exe_fwd_br_en_zext: exe_fwd_o = {{(`RV_XLEN-1){1'b0}}, br_en_i};
            exe_fwd_u_imm:      exe_fwd_o = u_imm_i;
            default:            exe_fwd_o = alu_out_i;
        endcase
    end

endmodule

//--- mem_wb_reg.sv
module mem_wb_reg (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    load_i,
    input  logic                    ready_i,
    input  logic                    br_en_i,
    input  logic                    wb_fwd_load_i,
    input  rv_pipe_pkg::ctrl_word_t ctrl_i,
    input  rv_pipe_pkg::rv_word_t   exe_fwd_i,
    input  rv_pipe_pkg::rv_word_t   u_imm_i,
    input  rv_pipe_pkg::rv_word_t   mem_rdata_i,
    input  rv_pipe_pkg::rv_word_t   wb_fwd_data_i,
    output rv_pipe_pkg::ctrl_word_t ctrl_o,
    output rv_pipe_pkg::rv_word_t   exe_fwd_o,
    output rv_pipe_pkg::rv_word_t   u_imm_o,
    output rv_pipe_pkg::rv_word_t   mem_rdata_o,
    output rv_pipe_pkg::rv_word_t   mem_fwd_data_o,
    output rv_pipe_pkg::rv_word_t   wb_fwd_data_o,
    output logic                    br_en_o,
    output logic                    valid_o,
    output logic                    ready_o
);
    import rv_pipe_pkg::*;

    rv_word_t mem_fwd_next;

    always_comb begin
        case (ctrl_i.mem.mem_fwd_sel)
            mem_fwd_exe: mem_fwd_next = exe_fwd_i;
            default:     mem_fwd_next = mem_rdata_i;
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            ctrl_o         <= ctrl_nop;
            exe_fwd_o      <= '0;
            mem_fwd_data_o <= '0;
            br_en_o        <= 1'b0;
            valid_o        <= 1'b0;
            ready_o        <= 1'b0;
        end else if (load_i) begin
            ctrl_o         <= ctrl_i;
            exe_fwd_o      <= exe_fwd_i;
            mem_fwd_data_o <= mem_fwd_next;
            br_en_o        <= br_en_i;
            valid_o        <= 1'b1;
            ready_o        <= ready_i;
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            u_imm_o     <= u_imm_i;
            mem_rdata_o <= mem_rdata_i;
        end
    end

    // writeback forward with its own strobe
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wb_fwd_data_o <= '0;
        end else if (wb_fwd_load_i) begin
            wb_fwd_data_o <= wb_fwd_data_i;
        end
    end

endmodule

//--- rv_pipe_config.svh
`ifndef RV_PIPE_CONFIG_SVH
`define RV_PIPE_CONFIG_SVH

// data and address width
`define RV_XLEN 32

// register file index width
`define RV_REG_IDX_W 5

// first fetch address out of reset
`define RV_PC_RESET 32'h4000_0000

// commit order counter width
`define RV_ORDER_W 64

// byte lanes per word
`define RV_MASK_W 4

`endif

//--- rv_pipe_pkg.sv
`include "rv_pipe_config.svh"

package rv_pipe_pkg;

    typedef logic [`RV_XLEN-1:0] rv_word_t;

    typedef enum logic [1:0] {
        exe_fwd_alu_out    = 2'b00,
        exe_fwd_br_en_zext = 2'b01,
        exe_fwd_u_imm      = 2'b10
    } exe_fwd_sel_e;

    typedef enum logic {
        mar_pc_out  = 1'b0,
        mar_alu_out = 1'b1
    } mar_sel_e;

    typedef enum logic {
        mem_fwd_rdata = 1'b0,
        mem_fwd_exe   = 1'b1
    } mem_fwd_sel_e;

    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_e;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_e;

    // same funct3 bits seen as load or store
    typedef union packed {
        load_funct3_e  ld;
        store_funct3_e st;
    } mem_funct3_u;

    typedef struct packed {
        exe_fwd_sel_e exe_fwd_sel;
    } exe_ctrl_t;

    typedef struct packed {
        logic         mem_read;
        logic         mem_write;
        mem_funct3_u  funct3;
        mar_sel_e     mar_sel;
        mem_fwd_sel_e mem_fwd_sel;
    } mem_ctrl_t;

    typedef struct packed {
        logic                     ld_reg;
        logic [2:0]               regfile_sel; // consumed by writeback mux
        logic [`RV_REG_IDX_W-1:0] rd_sel;
    } wb_ctrl_t;

    typedef struct packed {
        exe_ctrl_t exe;
        mem_ctrl_t mem;
        wb_ctrl_t  wb;
        rv_word_t  pc;
    } ctrl_word_t;

    typedef struct packed {
        rv_word_t               addr;
        rv_word_t               wdata;
        logic [`RV_MASK_W-1:0]  byte_en;
    } mem_req_t;

    // bubble with no memory access and no register write
    localparam ctrl_word_t ctrl_nop = '{
        exe: '{exe_fwd_sel: exe_fwd_alu_out},
        mem: '{mem_read: 1'b0, mem_write: 1'b0, funct3: '0,
               mar_sel: mar_pc_out, mem_fwd_sel: mem_fwd_rdata},
        wb:  '{ld_reg: 1'b0, regfile_sel: 3'b000, rd_sel: '0},
        pc:  `RV_PC_RESET
    };

endpackage

//--- rv_pipe_regs_top.sv
`include "rv_pipe_config.svh"

module rv_pipe_regs_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fd_load_i,
    input  logic                    de_load_i,
    input  logic                    em_load_i,
    input  logic                    mw_load_i,
    input  logic                    wb_fwd_load_i,
    input  rv_pipe_pkg::rv_word_t   instr_i,
    input  rv_pipe_pkg::rv_word_t   pc_i,
    input  rv_pipe_pkg::rv_word_t   pc_next_i,
    input  rv_pipe_pkg::ctrl_word_t ctrl_i,
    input  rv_pipe_pkg::rv_word_t   u_imm_i,
    input  rv_pipe_pkg::rv_word_t   alu_out_i,
    input  rv_pipe_pkg::rv_word_t   rs2_data_i,
    input  logic                    br_en_i,
    input  rv_pipe_pkg::rv_word_t   mem_rdata_i,
    input  rv_pipe_pkg::rv_word_t   wb_fwd_data_i,
    input  logic                    fd_ready_i,
    input  logic                    de_ready_i,
    input  logic                    em_ready_i,
    input  logic                    mw_ready_i,
    output rv_pipe_pkg::rv_word_t   instr_o,
    output rv_pipe_pkg::rv_word_t   pc_o,
    output rv_pipe_pkg::rv_word_t   pc_next_o,
    output logic                    fd_valid_o,
    output logic                    fd_ready_o,
    output logic [`RV_ORDER_W-1:0]  commit_order_o,
    output rv_pipe_pkg::ctrl_word_t ctrl_ex_o,
    output rv_pipe_pkg::rv_word_t   u_imm_ex_o,
    output logic                    de_valid_o,
    output logic                    de_ready_o,
    output rv_pipe_pkg::ctrl_word_t ctrl_mem_o,
    output rv_pipe_pkg::rv_word_t   exe_fwd_o,
    output rv_pipe_pkg::rv_word_t   u_imm_mem_o,
    output logic                    br_en_mem_o,
    output logic                    em_valid_o,
    output logic                    em_ready_o,
    output rv_pipe_pkg::mem_req_t   dmem_req_o,
    output rv_pipe_pkg::ctrl_word_t ctrl_wb_o,
    output rv_pipe_pkg::rv_word_t   exe_fwd_wb_o,
    output rv_pipe_pkg::rv_word_t   u_imm_wb_o,
    output rv_pipe_pkg::rv_word_t   mem_rdata_wb_o,
    output rv_pipe_pkg::rv_word_t   mem_fwd_data_o,
    output rv_pipe_pkg::rv_word_t   wb_fwd_data_o,
    output logic                    br_en_wb_o,
    output logic                    mw_valid_o,
    output logic                    mw_ready_o
);

    rv_pipe_pkg::mem_req_t mem_req_calc; // unregistered request
    rv_pipe_pkg::rv_word_t exe_fwd_calc;

    fetch_decode_reg fd_reg0 (
        .clk            (clk),
        .rst            (rst),
        .load_i         (fd_load_i),
        .ready_i        (fd_ready_i),
        .instr_i        (instr_i),
        .pc_i           (pc_i),
        .pc_next_i      (pc_next_i),
        .instr_o        (instr_o),
        .pc_o           (pc_o),
        .pc_next_o      (pc_next_o),
        .valid_o        (fd_valid_o),
        .ready_o        (fd_ready_o),
        .commit_order_o (commit_order_o)
    );

    // external decoder hands over a qualified control word every cycle
    decode_exec_reg de_reg0 (
        .clk     (clk),
        .rst     (rst),
        .load_i  (de_load_i),
        .ready_i (de_ready_i),
        .valid_i (1'b1),
        .ctrl_i  (ctrl_i),
        .u_imm_i (u_imm_i),
        .ctrl_o  (ctrl_ex_o),
        .u_imm_o (u_imm_ex_o),
        .valid_o (de_valid_o),
        .ready_o (de_ready_o)
    );

    mem_access_calc mac0 (
        .ctrl_i     (ctrl_ex_o),
        .alu_out_i  (alu_out_i),
        .u_imm_i    (u_imm_ex_o),
        .rs2_data_i (rs2_data_i),
        .br_en_i    (br_en_i),
        .mem_req_o  (mem_req_calc),
        .exe_fwd_o  (exe_fwd_calc)
    );

    exec_mem_reg em_reg0 (
        .clk       (clk),
        .rst       (rst),
        .load_i    (em_load_i),
        .ready_i   (em_ready_i),
        .br_en_i   (br_en_i),
        .ctrl_i    (ctrl_ex_o),
        .exe_fwd_i (exe_fwd_calc),
        .u_imm_i   (u_imm_ex_o),
        .mem_req_i (mem_req_calc),
        .ctrl_o    (ctrl_mem_o),
        .exe_fwd_o (exe_fwd_o),
        .u_imm_o   (u_imm_mem_o),
        .br_en_o   (br_en_mem_o),
        .valid_o   (em_valid_o),
        .ready_o   (em_ready_o),
        .mem_req_o (dmem_req_o)
    );

    mem_wb_reg mw_reg0 (
        .clk            (clk),
        .rst            (rst),
        .load_i         (mw_load_i),
        .ready_i        (mw_ready_i),
        .br_en_i        (br_en_mem_o),
        .wb_fwd_load_i  (wb_fwd_load_i),
        .ctrl_i         (ctrl_mem_o),
        .exe_fwd_i      (exe_fwd_o),
        .u_imm_i        (u_imm_mem_o),
        .mem_rdata_i    (mem_rdata_i),
        .wb_fwd_data_i  (wb_fwd_data_i),
        .ctrl_o         (ctrl_wb_o),
        .exe_fwd_o      (exe_fwd_wb_o),
        .u_imm_o        (u_imm_wb_o),
        .mem_rdata_o    (mem_rdata_wb_o),
        .mem_fwd_data_o (mem_fwd_data_o),
        .wb_fwd_data_o  (wb_fwd_data_o),
        .br_en_o        (br_en_wb_o),
        .valid_o        (mw_valid_o),
        .ready_o        (mw_ready_o)
    );

endmodule

//--- tb_rv_pipe_regs.sv
`include "rv_pipe_config.svh"

module tb_rv_pipe_regs;
    import rv_pipe_pkg::*;

    localparam int CLK_PERIOD     = 100;
    localparam int DRIVE_DELAY    = 10;
    localparam int RESET_CYCLES   = 5;
    localparam int FULL_CYCLES    = 40;
    localparam int RANDOM_CYCLES  = 400;
    localparam int STALL_CYCLES   = 12;
    localparam int DRAIN_CYCLES   = 4;
    localparam int PLANNED_CYCLES = RESET_CYCLES + FULL_CYCLES + RANDOM_CYCLES
                                    + 5 * STALL_CYCLES + DRAIN_CYCLES;

    typedef struct packed {
        rv_word_t               instr;
        rv_word_t               pc;
        rv_word_t               pc_next;
        logic                   valid;
        logic                   ready;
        logic [`RV_ORDER_W-1:0] order;
    } fd_model_t;

    typedef struct packed {
        ctrl_word_t ctrl;
        rv_word_t   u_imm;
        logic       valid;
        logic       ready;
    } de_model_t;

    typedef struct packed {
        ctrl_word_t ctrl;
        rv_word_t   exe_fwd;
        rv_word_t   u_imm;
        logic       br_en;
        logic       valid;
        logic       ready;
        mem_req_t   req;
    } em_model_t;

    typedef struct packed {
        ctrl_word_t ctrl;
        rv_word_t   exe_fwd;
        rv_word_t   u_imm;
        rv_word_t   mem_rdata;
        rv_word_t   mem_fwd;
        rv_word_t   wb_fwd;
        logic       br_en;
        logic       valid;
        logic       ready;
    } mw_model_t;

    logic   clk = 1'b0;
    logic   rst;
    integer seed;

    logic       fd_load_i, de_load_i, em_load_i, mw_load_i, wb_fwd_load_i;
    logic       fd_ready_i, de_ready_i, em_ready_i, mw_ready_i;
    logic       br_en_i;
    rv_word_t   instr_i, pc_i, pc_next_i, u_imm_i, alu_out_i, rs2_data_i;
    rv_word_t   mem_rdata_i, wb_fwd_data_i;
    ctrl_word_t ctrl_i;

    rv_word_t               instr_o, pc_o, pc_next_o;
    logic                   fd_valid_o, fd_ready_o;
    logic [`RV_ORDER_W-1:0] commit_order_o;
    ctrl_word_t             ctrl_ex_o, ctrl_mem_o, ctrl_wb_o;
    rv_word_t               u_imm_ex_o, u_imm_mem_o, u_imm_wb_o;
    logic                   de_valid_o, de_ready_o;
    rv_word_t               exe_fwd_o, exe_fwd_wb_o, mem_rdata_wb_o;
    rv_word_t               mem_fwd_data_o, wb_fwd_data_o;
    logic                   br_en_mem_o, br_en_wb_o;
    logic                   em_valid_o, em_ready_o, mw_valid_o, mw_ready_o;
    mem_req_t               dmem_req_o;

    fd_model_t ref_fd;
    de_model_t ref_de;
    em_model_t ref_em;
    mw_model_t ref_mw;

    rv_pipe_regs_top dut0 (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic ctrl_word_t idle_ctrl();
        ctrl_word_t c;
        c    = '0;
        c.pc = `RV_PC_RESET;
        return c;
    endfunction

    // bytes touched per access or 0 without any lanes
    function automatic int access_size(input logic rd, input logic wr, input logic [2:0] f3);
        if (rd) begin
            case (f3)
                lb, lbu: return 1;
                lh, lhu: return 2;
                lw:      return 4;
                default: return 0;
            endcase
        end else if (wr) begin
            case (f3)
                sb:      return 1;
                sh:      return 2;
                sw:      return 4;
                default: return 0;
            endcase
        end
        return 0;
    endfunction

    function automatic mem_req_t expect_req(input ctrl_word_t c, input rv_word_t alu,
                                            input rv_word_t rs2);
        mem_req_t r;
        rv_word_t a;
        int       size;
        a         = (c.mem.mar_sel == mar_alu_out) ? alu : c.pc;
        size      = access_size(c.mem.mem_read, c.mem.mem_write, c.mem.funct3);
        r.addr    = a;
        r.wdata   = rs2;
        r.byte_en = '0;
        if (size == 4) begin
            r.byte_en = 4'b1111;
        end else if (size != 0) begin
            r.addr    = {a[`RV_XLEN-1:2], 2'b00};
            r.byte_en = ((size == 2) ? 4'b0011 : 4'b0001) << a[1:0]; // upper lanes fall off
        end
        return r;
    endfunction

    function automatic rv_word_t expect_exe_fwd(input ctrl_word_t c, input rv_word_t alu,
                                                input rv_word_t u_imm, input logic br);
        case (c.exe.exe_fwd_sel)
            exe_fwd_br_en_zext: return rv_word_t'(br);
            exe_fwd_u_imm:      return u_imm;
            default:            return alu;
        endcase
    endfunction

    function automatic ctrl_word_t random_ctrl();
        ctrl_word_t  c;
        logic [63:0] raw;
        raw               = {$random(seed), $random(seed)};
        c                 = raw[$bits(ctrl_word_t)-1:0];
        c.exe.exe_fwd_sel = exe_fwd_sel_e'(2'($unsigned($random(seed)) % 3));
        c.mem.mem_write   = c.mem.mem_write & ~c.mem.mem_read; // one direction at most
        return c;
    endfunction

    // reference model of the stage registers
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            ref_fd.valid       <= 1'b0;
            ref_fd.ready       <= 1'b0;
            ref_fd.order       <= '0;
            ref_de.ctrl        <= idle_ctrl();
            ref_de.valid       <= 1'b0;
            ref_de.ready       <= 1'b0;
            ref_em.ctrl        <= idle_ctrl();
            ref_em.exe_fwd     <= '0;
            ref_em.br_en       <= 1'b0;
            ref_em.valid       <= 1'b0;
            ref_em.ready       <= 1'b0;
            ref_em.req.byte_en <= '0;
            ref_mw.ctrl        <= idle_ctrl();
            ref_mw.exe_fwd     <= '0;
            ref_mw.mem_fwd     <= '0;
            ref_mw.wb_fwd      <= '0;
            ref_mw.br_en       <= 1'b0;
            ref_mw.valid       <= 1'b0;
            ref_mw.ready       <= 1'b0;
        end else begin
            if (fd_load_i) begin
                ref_fd.instr   <= instr_i;
                ref_fd.pc      <= pc_i;
                ref_fd.pc_next <= pc_next_i;
                ref_fd.valid   <= 1'b1;
                ref_fd.ready   <= fd_ready_i;
                ref_fd.order   <= ref_fd.order + 1;
            end
            if (de_load_i) begin
                ref_de.ctrl  <= ctrl_i;
                ref_de.u_imm <= u_imm_i;
                ref_de.valid <= 1'b1;
                ref_de.ready <= de_ready_i;
            end
            if (em_load_i) begin
                ref_em.ctrl    <= ref_de.ctrl;
                ref_em.exe_fwd <= expect_exe_fwd(ref_de.ctrl, alu_out_i, ref_de.u_imm, br_en_i);
                ref_em.u_imm   <= ref_de.u_imm;
                ref_em.br_en   <= br_en_i;
                ref_em.valid   <= 1'b1;
                ref_em.ready   <= em_ready_i;
                if (ref_de.ctrl.mem.mem_read || ref_de.ctrl.mem.mem_write) begin
                    ref_em.req <= expect_req(ref_de.ctrl, alu_out_i, rs2_data_i);
                end
            end
            if (mw_load_i) begin
                ref_mw.ctrl      <= ref_em.ctrl;
                ref_mw.exe_fwd   <= ref_em.exe_fwd;
                ref_mw.u_imm     <= ref_em.u_imm;
                ref_mw.mem_rdata <= mem_rdata_i;
                ref_mw.mem_fwd   <= (ref_em.ctrl.mem.mem_fwd_sel == mem_fwd_exe) ?
                                    ref_em.exe_fwd : mem_rdata_i;
                ref_mw.br_en     <= ref_em.br_en;
                ref_mw.valid     <= 1'b1;
                ref_mw.ready     <= mw_ready_i;
            end
            if (wb_fwd_load_i) begin
                ref_mw.wb_fwd <= wb_fwd_data_i;
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] expected);
        $display("MISMATCH %s: dut %0h, expected %0h", name, got, expected);
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    assert property (@(negedge clk) instr_o === ref_fd.instr)
        else report_mismatch("instr_o", instr_o, ref_fd.instr);
    assert property (@(negedge clk) pc_o === ref_fd.pc)
        else report_mismatch("pc_o", pc_o, ref_fd.pc);
    assert property (@(negedge clk) pc_next_o === ref_fd.pc_next)
        else report_mismatch("pc_next_o", pc_next_o, ref_fd.pc_next);
    assert property (@(negedge clk) fd_valid_o === ref_fd.valid)
        else report_mismatch("fd_valid_o", fd_valid_o, ref_fd.valid);
    assert property (@(negedge clk) fd_ready_o === ref_fd.ready)
        else report_mismatch("fd_ready_o", fd_ready_o, ref_fd.ready);
    assert property (@(negedge clk) commit_order_o === ref_fd.order)
        else report_mismatch("commit_order_o", commit_order_o, ref_fd.order);
    assert property (@(negedge clk) ctrl_ex_o === ref_de.ctrl)
        else report_mismatch("ctrl_ex_o", ctrl_ex_o, ref_de.ctrl);
    assert property (@(negedge clk) u_imm_ex_o === ref_de.u_imm)
        else report_mismatch("u_imm_ex_o", u_imm_ex_o, ref_de.u_imm);
    assert property (@(negedge clk) de_valid_o === ref_de.valid)
        else report_mismatch("de_valid_o", de_valid_o, ref_de.valid);
    assert property (@(negedge clk) de_ready_o === ref_de.ready)
        else report_mismatch("de_ready_o", de_ready_o, ref_de.ready);
    assert property (@(negedge clk) ctrl_mem_o === ref_em.ctrl)
        else report_mismatch("ctrl_mem_o", ctrl_mem_o, ref_em.ctrl);
    assert property (@(negedge clk) exe_fwd_o === ref_em.exe_fwd)
        else report_mismatch("exe_fwd_o", exe_fwd_o, ref_em.exe_fwd);
    assert property (@(negedge clk) u_imm_mem_o === ref_em.u_imm)
        else report_mismatch("u_imm_mem_o", u_imm_mem_o, ref_em.u_imm);
    assert property (@(negedge clk) br_en_mem_o === ref_em.br_en)
        else report_mismatch("br_en_mem_o", br_en_mem_o, ref_em.br_en);
    assert property (@(negedge clk) em_valid_o === ref_em.valid)
        else report_mismatch("em_valid_o", em_valid_o, ref_em.valid);
    assert property (@(negedge clk) em_ready_o === ref_em.ready)
        else report_mismatch("em_ready_o", em_ready_o, ref_em.ready);
    assert property (@(negedge clk) dmem_req_o === ref_em.req)
        else report_mismatch("dmem_req_o", dmem_req_o, ref_em.req);
    assert property (@(negedge clk) ctrl_wb_o === ref_mw.ctrl)
        else report_mismatch("ctrl_wb_o", ctrl_wb_o, ref_mw.ctrl);
    assert property (@(negedge clk) exe_fwd_wb_o === ref_mw.exe_fwd)
        else report_mismatch("exe_fwd_wb_o", exe_fwd_wb_o, ref_mw.exe_fwd);
    assert property (@(negedge clk) u_imm_wb_o === ref_mw.u_imm)
        else report_mismatch("u_imm_wb_o", u_imm_wb_o, ref_mw.u_imm);
    assert property (@(negedge clk) mem_rdata_wb_o === ref_mw.mem_rdata)
        else report_mismatch("mem_rdata_wb_o", mem_rdata_wb_o, ref_mw.mem_rdata);
    assert property (@(negedge clk) mem_fwd_data_o === ref_mw.mem_fwd)
        else report_mismatch("mem_fwd_data_o", mem_fwd_data_o, ref_mw.mem_fwd);
    assert property (@(negedge clk) wb_fwd_data_o === ref_mw.wb_fwd)
        else report_mismatch("wb_fwd_data_o", wb_fwd_data_o, ref_mw.wb_fwd);
    assert property (@(negedge clk) br_en_wb_o === ref_mw.br_en)
        else report_mismatch("br_en_wb_o", br_en_wb_o, ref_mw.br_en);
    assert property (@(negedge clk) mw_valid_o === ref_mw.valid)
        else report_mismatch("mw_valid_o", mw_valid_o, ref_mw.valid);
    assert property (@(negedge clk) mw_ready_o === ref_mw.ready)
        else report_mismatch("mw_ready_o", mw_ready_o, ref_mw.ready);

    // strobes in order fd, de, em, mw, wb_fwd
    task automatic drive_inputs(input logic [4:0] loads);
        @(posedge clk);
        #DRIVE_DELAY;
        {fd_load_i, de_load_i, em_load_i, mw_load_i, wb_fwd_load_i} = loads;
        {fd_ready_i, de_ready_i, em_ready_i, mw_ready_i} = 4'($random(seed));
        br_en_i       = 1'($random(seed));
        instr_i       = $random(seed);
        pc_i          = $random(seed);
        pc_next_i     = $random(seed);
        u_imm_i       = $random(seed);
        alu_out_i     = $random(seed);
        rs2_data_i    = $random(seed);
        mem_rdata_i   = $random(seed);
        wb_fwd_data_i = $random(seed);
        ctrl_i        = random_ctrl();
    endtask

    initial begin
        #((PLANNED_CYCLES + 20) * CLK_PERIOD);
        $display("timeout, the test sequence did not finish in the expected time");
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed          = 32'h1107_e73c;
        rst           = 1'b1;
        {fd_load_i, de_load_i, em_load_i, mw_load_i, wb_fwd_load_i} = '0;
        {fd_ready_i, de_ready_i, em_ready_i, mw_ready_i} = '0;
        br_en_i       = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        pc_next_i     = '0;
        u_imm_i       = '0;
        alu_out_i     = '0;
        rs2_data_i    = '0;
        mem_rdata_i   = '0;
        wb_fwd_data_i = '0;
        ctrl_i        = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        repeat (FULL_CYCLES) drive_inputs(5'b11111); // straight flow with 3 cycle latency
        repeat (RANDOM_CYCLES) drive_inputs(5'($random(seed)));
        for (int s = 0; s < 5; s++) begin
            repeat (STALL_CYCLES) drive_inputs(5'b11111 & ~(5'b10000 >> s)); // one stage frozen
        end
        repeat (DRAIN_CYCLES) drive_inputs(5'b11111);

        @(posedge clk);
        @(negedge clk);
        #1;
        $display("Test OK");
        $finish;
    end

endmodule
